// ==== design/audio_pkg.sv ====
package audio_pkg;

    //----------------------------------------
    // Sample widths

    localparam int sample_bits = 24;         // INMP441 word
    localparam int sound_bits  = 16;         // Codec word

    typedef logic signed [sample_bits - 1:0] sample_t;
    typedef logic signed [sound_bits  - 1:0] sound_t;
    typedef logic        [              2:0] vol_t;     // Right-shift count
    typedef logic        [              3:0] fill_t;    // 0 to 8 entries

    //----------------------------------------
    // I2S timing

    localparam int half_bit_clks = 4;        // clk cycles per bclk half period
    localparam int div_bits      = $clog2 (half_bit_clks);

    localparam int slot_bits     = 32;       // bclk periods per channel slot
    localparam int idx_bits      = $clog2 (slot_bits);

    //----------------------------------------
    // FIFO

    localparam int fifo_depth  = 8;
    localparam int ptr_bits    = $clog2 (fifo_depth);
    localparam int prime_level = 2;          // Entries before first offer

    //----------------------------------------
    // State machines

    typedef enum logic [1:0]
    {
        RX_WAIT_SLOT,
        RX_SHIFT,
        RX_OFFER,
        RX_RELEASE
    } rx_state_t;

    typedef enum logic [1:0]
    {
        HS_IDLE,
        HS_OFFER,
        HS_RELEASE
    } hs_state_t;

    typedef enum logic
    {
        TX_REQUEST,
        TX_LATCHED
    } tx_state_t;

endpackage

// ==== design/i2s_clock_gen.sv ====
`timescale 1ns/1ps

module i2s_clock_gen
    import audio_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    output logic                  bclk,
    output logic                  lrclk,
    output logic                  bit_rise,
    output logic                  bit_fall,
    output logic                  slot_right,
    output logic [idx_bits - 1:0] bit_idx
);

    logic [div_bits - 1:0] div_cnt;
    logic                  half_done;

    assign half_done = (div_cnt == div_bits'(half_bit_clks - 1));

    //----------------------------------------
    // Bit clock and edge strobes

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt  <= '0;
            bclk     <= 1'b0;
            bit_rise <= 1'b0;
            bit_fall <= 1'b0;
        end
        else
        begin
            div_cnt  <= half_done ? '0 : div_cnt + 1'b1;
            bit_rise <= half_done && !bclk;   // High with the new bclk level
            bit_fall <= half_done &&  bclk;

            if (half_done)
                bclk <= !bclk;
        end
    end

    //----------------------------------------
    // Bit index and slot, both move on the falling edge

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bit_idx    <= '0;
            slot_right <= 1'b0;
        end
        else if (half_done && bclk)
        begin
            bit_idx <= bit_idx + 1'b1;        // Wraps at slot_bits

            if (bit_idx == idx_bits'(slot_bits - 1))
                slot_right <= !slot_right;
        end
    end

    assign lrclk = slot_right;                // Low selects the left channel

endmodule

// ==== design/mic_i2s_receiver.sv ====
`timescale 1ns/1ps

module mic_i2s_receiver
    import audio_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  bit_rise,
    input  logic                  slot_right,
    input  logic [idx_bits - 1:0] bit_idx,
    input  logic                  sd,

    input  logic                  in_ack,
    output logic                  in_req,
    output sample_t               in_data
);

    rx_state_t state;
    sample_t   shift_reg;

    logic      first_bit;
    logic      last_bit;
    logic      shift_en;

    // Bit 0 of the slot is the I2S delay bit, MSB comes on bit 1
    assign first_bit = bit_rise && !slot_right && (bit_idx == idx_bits'(1));
    assign last_bit  = bit_rise && (bit_idx == idx_bits'(sample_bits));

    assign shift_en  = ((state == RX_WAIT_SLOT) && first_bit)
                    || ((state == RX_SHIFT)     && bit_rise);

    //----------------------------------------
    // Control FSM

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= RX_WAIT_SLOT;
            in_req <= 1'b0;
        end
        else
        begin
            case (state)
                RX_WAIT_SLOT:
                begin
                    if (first_bit)
                        state <= RX_SHIFT;
                end

                RX_SHIFT:
                begin
                    if (last_bit)
                    begin
                        in_req <= 1'b1;       // Word is ready next cycle
                        state  <= RX_OFFER;
                    end
                end

                // Held here until the FIFO takes the word
                RX_OFFER:
                begin
                    if (in_ack)
                    begin
                        in_req <= 1'b0;
                        state  <= RX_RELEASE;
                    end
                end

                RX_RELEASE:
                begin
                    if (!in_ack)
                        state <= RX_WAIT_SLOT;
                end

                default:
                    state <= RX_WAIT_SLOT;
            endcase
        end
    end

    //----------------------------------------
    // Data path

    always_ff @(posedge clk)
    begin
        if (shift_en)
            shift_reg <= { shift_reg [sample_bits - 2:0], sd };  // MSB first

        // Only loaded while req and ack are both low
        if ((state == RX_SHIFT) && last_bit)
            in_data <= { shift_reg [sample_bits - 2:0], sd };
    end

endmodule

// ==== design/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo
    import audio_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    // Producer side
    input  logic    in_req,
    input  sample_t in_data,
    output logic    in_ack,

    // Consumer side
    output logic    out_req,
    output sample_t out_data,
    input  logic    out_ack,

    output fill_t   fill
);

    sample_t               mem [fifo_depth];

    logic [ptr_bits - 1:0] wr_ptr;
    logic [ptr_bits - 1:0] rd_ptr;

    hs_state_t             state;
    logic                  primed;
    logic                  full;
    logic                  wr_en;
    logic                  rd_en;
    logic                  offer_start;

    assign full        = (fill == fill_t'(fifo_depth));
    assign wr_en       = in_req && !in_ack && !full;   // Ack held low when full
    assign rd_en       = (state == HS_OFFER) && out_ack;
    assign offer_start = (state == HS_IDLE) && primed && (fill != '0);

    //----------------------------------------
    // Storage

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem [wr_ptr] <= in_data;
    end

    // Head entry, stable for the whole offer
    always_ff @(posedge clk)
    begin
        if (offer_start)
            out_data <= mem [rd_ptr];
    end

    //----------------------------------------
    // Input handshake

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            in_ack <= 1'b0;
        end
        else if (wr_en)
        begin
            wr_ptr <= wr_ptr + 1'b1;
            in_ack <= 1'b1;
        end
        else if (!in_req)
            in_ack <= 1'b0;                           // Req gone, release
    end

    //----------------------------------------
    // Occupancy

    always_ff @(posedge clk)
    begin
        if (reset)
            fill <= '0;
        else
        begin
            case ({ wr_en, rd_en })
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Sticky until reset
    always_ff @(posedge clk)
    begin
        if (reset)
            primed <= 1'b0;
        else if (fill >= fill_t'(prime_level))
            primed <= 1'b1;
    end

    //----------------------------------------
    // Output handshake FSM

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= HS_IDLE;
            out_req <= 1'b0;
            rd_ptr  <= '0;
        end
        else
        begin
            case (state)
                HS_IDLE:
                begin
                    if (offer_start)
                    begin
                        out_req <= 1'b1;
                        state   <= HS_OFFER;
                    end
                end

                HS_OFFER:
                begin
                    if (out_ack)
                    begin
                        out_req <= 1'b0;
                        rd_ptr  <= rd_ptr + 1'b1;     // Pop
                        state   <= HS_RELEASE;
                    end
                end

                HS_RELEASE:
                begin
                    if (!out_ack)
                        state <= HS_IDLE;
                end

                default:
                    state <= HS_IDLE;
            endcase
        end
    end

endmodule

// ==== design/i2s_audio_out.sv ====
`timescale 1ns/1ps

module i2s_audio_out
    import audio_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  bit_fall,
    input  logic                  slot_right,
    input  logic [idx_bits - 1:0] bit_idx,

    input  logic                  out_req,
    input  sample_t               out_data,
    output logic                  out_ack,

    input  vol_t                  vol,
    output logic                  sdata
);

    tx_state_t state;

    sound_t    scaled;
    sound_t    next_word;
    sound_t    sound_word;   // Value for the current frame
    sound_t    tx_shift;

    logic      slot_start;
    logic      frame_start;
    logic      take;

    assign slot_start  = bit_fall && (bit_idx == '0);
    assign frame_start = slot_start && !slot_right;
    assign take        = frame_start && out_req && (state == TX_REQUEST);

    // Top 16 bits, then attenuate keeping the sign
    assign scaled    = $signed (out_data [sample_bits - 1 -: sound_bits]) >>> vol;

    assign next_word = take ? scaled : '0;   // Silence without a sample

    //----------------------------------------
    // Handshake FSM

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= TX_REQUEST;
            out_ack <= 1'b0;
        end
        else
        begin
            case (state)
                TX_REQUEST:
                begin
                    if (take)
                    begin
                        out_ack <= 1'b1;
                        state   <= TX_LATCHED;
                    end
                end

                TX_LATCHED:
                begin
                    if (!out_req)
                    begin
                        out_ack <= 1'b0;
                        state   <= TX_REQUEST;
                    end
                end

                default:
                    state <= TX_REQUEST;
            endcase
        end
    end

    //----------------------------------------
    // Frame word, kept for the right slot

    always_ff @(posedge clk)
    begin
        if (reset)
            sound_word <= '0;
        else if (frame_start)
            sound_word <= next_word;
    end

    //----------------------------------------
    // Serializer

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tx_shift <= '0;
            sdata    <= 1'b0;
        end
        else if (bit_fall)
        begin
            if (bit_idx == '0)
            begin
                // Delay bit, load the slot word
                tx_shift <= slot_right ? sound_word : next_word;
                sdata    <= 1'b0;
            end
            else if (bit_idx <= idx_bits'(sound_bits))
            begin
                sdata    <= tx_shift [sound_bits - 1];
                tx_shift <= tx_shift << 1;
            end
            else
                sdata    <= 1'b0;                    // Padding up to slot end
        end
    end

endmodule

// ==== design/audio_loop_top.sv ====
`timescale 1ns/1ps

module audio_loop_top
    import audio_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    input  vol_t  vol,

    // INMP441 microphone
    output logic  mic_sck,
    output logic  mic_ws,
    input  logic  mic_sd,

    // Codec
    output logic  aud_bclk,
    output logic  aud_lrclk,
    output logic  aud_sdata,

    output fill_t led
);

    //----------------------------------------
    // Shared I2S timing

    logic                  bclk;
    logic                  lrclk;
    logic                  bit_rise;
    logic                  bit_fall;
    logic                  slot_right;
    logic [idx_bits - 1:0] bit_idx;

    // Handshakes
    logic                  in_req;
    logic                  in_ack;
    sample_t               in_data;
    logic                  out_req;
    logic                  out_ack;
    sample_t               out_data;

    assign mic_sck   = bclk;      // Both sides share one frame rate
    assign mic_ws    = lrclk;
    assign aud_bclk  = bclk;
    assign aud_lrclk = lrclk;

    i2s_clock_gen i_clock_gen
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .bclk       ( bclk       ),
        .lrclk      ( lrclk      ),
        .bit_rise   ( bit_rise   ),
        .bit_fall   ( bit_fall   ),
        .slot_right ( slot_right ),
        .bit_idx    ( bit_idx    )
    );

    mic_i2s_receiver i_microphone
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .bit_rise   ( bit_rise   ),
        .slot_right ( slot_right ),
        .bit_idx    ( bit_idx    ),
        .sd         ( mic_sd     ),
        .in_ack     ( in_ack     ),
        .in_req     ( in_req     ),
        .in_data    ( in_data    )
    );

    sample_fifo i_fifo
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .in_req     ( in_req     ),
        .in_data    ( in_data    ),
        .in_ack     ( in_ack     ),
        .out_req    ( out_req    ),
        .out_data   ( out_data   ),
        .out_ack    ( out_ack    ),
        .fill       ( led        )  // Fill level on the LEDs
    );

    i2s_audio_out i_audio_out
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .bit_fall   ( bit_fall   ),
        .slot_right ( slot_right ),
        .bit_idx    ( bit_idx    ),
        .out_req    ( out_req    ),
        .out_data   ( out_data   ),
        .out_ack    ( out_ack    ),
        .vol        ( vol        ),
        .sdata      ( aud_sdata  )
    );

endmodule

// ==== dv/tb_audio_loop.sv ====
`timescale 1ns/1ps

module tb_audio_loop
    import audio_pkg::*;
();

    localparam int frame_clks = 4 * slot_bits * half_bit_clks;   // 512 clk cycles
    localparam int num_rows   = 11;
    localparam int order_len  = 12;

    logic    clk    = 1'b0;
    logic    reset;
    vol_t    vol;
    logic    mic_sck;
    logic    mic_ws;
    logic    mic_sd = 1'b0;
    logic    aud_bclk;
    logic    aud_lrclk;
    logic    aud_sdata;
    fill_t   led;

    // Stimulus table with its expected outputs
    sample_t row_sample [num_rows];
    vol_t    row_vol    [num_rows];
    sound_t  row_exp    [num_rows];

    sound_t  dec_left_q  [$];
    sound_t  dec_right_q [$];
    int      dec_count  = 0;
    logic    watch_fill = 1'b0;
    int      pass_count = 0;
    int      fail_count = 0;
    int      fill_pass  = 0;
    int      fill_fail  = 0;
    sample_t mic_next;

    audio_loop_top u_dut
    (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .vol       ( vol       ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_sd    ( mic_sd    ),
        .aud_bclk  ( aud_bclk  ),
        .aud_lrclk ( aud_lrclk ),
        .aud_sdata ( aud_sdata ),
        .led       ( led       )
    );

    always #5 clk = ~clk;

    //----------------------------------------
    // Microphone model for the left channel

    sample_t mic_word;
    logic    mic_lr;
    logic    mic_sck_d;
    int      mic_idx;

    always @(negedge clk)
    begin
        if (reset)
        begin
            mic_lr   = 1'b0;                     // DUT restarts at left bit 0
            mic_idx  = 0;
            mic_word = mic_next;
            mic_sd  <= 1'b0;
        end
        else if (mic_sck_d && !mic_sck)
        begin
            if (mic_ws != mic_lr)
            begin
                mic_lr  = mic_ws;
                mic_idx = 0;
                if (!mic_ws)
                    mic_word = mic_next;         // New frame
            end
            else
                mic_idx = mic_idx + 1;

            if (!mic_lr && mic_idx >= 1 && mic_idx <= sample_bits)
                mic_sd <= mic_word[sample_bits - mic_idx];
            else
                mic_sd <= 1'b0;
        end
        mic_sck_d = mic_sck;
    end

    //----------------------------------------
    // I2S decoder on the codec pins

    sound_t  dec_left;
    sound_t  dec_right;
    logic    dec_lr;
    logic    dec_live;
    logic    dec_bclk_d;
    int      dec_idx;

    always @(negedge clk)
    begin
        if (reset)
        begin
            dec_lr   = 1'b1;
            dec_live = 1'b0;
            dec_idx  = 0;
        end
        else if (aud_bclk && !dec_bclk_d)
        begin
            if (aud_lrclk != dec_lr)
            begin
                dec_lr  = aud_lrclk;
                dec_idx = 0;
                if (!aud_lrclk)
                begin
                    // Previous frame complete
                    if (dec_live)
                    begin
                        dec_left_q.push_back(dec_left);
                        dec_right_q.push_back(dec_right);
                        dec_count <= dec_count + 1;
                    end
                    dec_live = 1'b1;
                    if (watch_fill)
                        check_fill("led", led, fill_t'(prime_level + 1));
                end
            end
            else
                dec_idx = dec_idx + 1;

            if (dec_idx >= 1 && dec_idx <= sound_bits)
            begin
                if (dec_lr)
                    dec_right = {dec_right[sound_bits - 2:0], aud_sdata};
                else
                    dec_left  = {dec_left[sound_bits - 2:0], aud_sdata};
            end
        end
        dec_bclk_d = aud_bclk;
    end

    //----------------------------------------
    // Checks and helpers

    // Output bit i comes from sample bit 8 + vol + i or else the sign bit
    function automatic sound_t expected_sound(input sample_t s, input vol_t v);
        sound_t res;
        int     src;
        for (int i = 0; i < sound_bits; i++)
        begin
            src = i + sample_bits - sound_bits + int'(v);
            if (src < sample_bits)
                res[i] = s[src];
            else
                res[i] = s[sample_bits - 1];    // Sign fill
        end
        return res;
    endfunction

    task automatic check_sound(input string name, input sound_t got, input sound_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_count++;
        end
        else
            pass_count++;
    endtask

    task automatic check_fill(input string name, input fill_t got, input fill_t max);
        if (got == '0 || got > max)
        begin
            $display("FAILED %s: got 0x%h, expected 0x1 to 0x%h", name, got, max);
            fill_fail++;
        end
        else
            fill_pass++;
    endtask

    task automatic check_level(input string name, input fill_t got, input fill_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_count++;
        end
        else
            pass_count++;
    endtask

    task automatic check_copy(input int first);
        for (int k = first; k < dec_left_q.size(); k++)
            check_sound("aud_sdata right", dec_right_q[k], dec_left_q[k]);
    endtask

    task automatic set_row(input int r, input sample_t s, input vol_t v, input sound_t e);
        row_sample[r] = s;
        row_vol[r]    = v;
        row_exp[r]    = e;
    endtask

    task automatic fill_table();
        set_row(0, 24'h7FFFFF, 3'd0, 16'h7FFF);   // Full scale positive
        set_row(1, 24'h800000, 3'd0, 16'h8000);   // Full scale negative
        set_row(2, 24'h000000, 3'd3, 16'h0000);
        set_row(3, 24'hFFFF00, 3'd0, 16'hFFFF);   // Small negative
        set_row(4, 24'hFFF000, 3'd2, 16'hFFFC);
        set_row(5, 24'h7FFFFF, 3'd7, 16'h00FF);
        set_row(6, 24'h800000, 3'd5, 16'hFC00);
        set_row(7, 24'hFFFFFF, 3'd4, 16'hFFFF);   // Sign fills the word
        for (int r = 8; r < num_rows; r++)
            set_row(r, sample_t'($urandom()), vol_t'($urandom()), '0);
        for (int r = 8; r < num_rows; r++)
            row_exp[r] = expected_sound(row_sample[r], row_vol[r]);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int target;
        int waited;
        target = dec_count + n;
        waited = 0;
        while (dec_count < target && waited < (n + 1) * frame_clks)
        begin
            @(negedge clk);
            waited++;
        end
        if (dec_count < target)
        begin
            $display("Timeout: no complete I2S frame decoded within %0d cycles", waited);
            $display("Testbench failed");
            $finish;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (fail_count == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, fail_count - errs_before);
    endtask

    //----------------------------------------
    // Test sequence

    initial
    begin
        int      errs;
        int      base;
        int      first;
        int      n;
        logic    dup;
        sample_t cand;
        sample_t seq     [order_len];
        sound_t  exp_seq [order_len];

        void'($urandom(73));
        reset    = 1'b1;
        vol      = '0;
        mic_next = '0;
        fill_table();
        apply_reset();

        errs = fail_count;
        wait_frames(1);
        check_sound("aud_sdata left", dec_left_q[$], '0);
        check_sound("aud_sdata right", dec_right_q[$], '0);
        report_test("silence before priming", errs);
        watch_fill = 1'b1;

        // Distinct nonzero outputs so the sequence can be found again
        n = 0;
        while (n < order_len)
        begin
            cand = sample_t'($urandom());
            dup  = (expected_sound(cand, '0) == '0);
            for (int j = 0; j < n; j++)
                if (exp_seq[j] == expected_sound(cand, '0))
                    dup = 1'b1;
            if (!dup)
            begin
                seq[n]     = cand;
                exp_seq[n] = expected_sound(cand, '0);
                n++;
            end
        end

        errs = fail_count;
        base = dec_left_q.size();
        for (int i = 0; i < order_len; i++)
        begin
            mic_next = seq[i];
            wait_frames(1);
        end
        mic_next = '0;
        wait_frames(5);
        first = -1;
        for (int k = base; k < dec_left_q.size(); k++)
            if (first < 0 && dec_left_q[k] == exp_seq[0])
                first = k;
        if (first < 0 || first + order_len > dec_left_q.size())
        begin
            $display("Sample order: the sent sequence never came out complete");
            fail_count++;
        end
        else
            for (int i = 0; i < order_len; i++)
                check_sound("aud_sdata left", dec_left_q[first + i], exp_seq[i]);
        check_copy(base);
        report_test("sample order", errs);

        for (int r = 0; r < num_rows; r++)
        begin
            errs     = fail_count;
            base     = dec_left_q.size();
            vol      = row_vol[r];
            mic_next = row_sample[r];
            wait_frames(6);
            check_sound("aud_sdata left", dec_left_q[$], row_exp[r]);
            check_copy(base);
            report_test($sformatf("attenuation row %0d", r), errs);
        end

        // Reset while samples are playing
        errs       = fail_count;
        watch_fill = 1'b0;
        apply_reset();
        check_level("led", led, '0);
        wait_frames(1);
        check_sound("aud_sdata left", dec_left_q[$], '0);
        check_sound("aud_sdata right", dec_right_q[$], '0);
        report_test("reset mid-stream", errs);

        $display("fill level: %0d frame starts checked, %0d errors",
                 fill_pass + fill_fail, fill_fail);
        $display("Checks passed: %0d, failed: %0d",
                 pass_count + fill_pass, fail_count + fill_fail);
        if (fail_count + fill_fail == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== list.f ====
design/audio_pkg.sv
design/i2s_clock_gen.sv
design/mic_i2s_receiver.sv
design/sample_fifo.sv
design/i2s_audio_out.sv
design/audio_loop_top.sv
dv/tb_audio_loop.sv

// ==== Makefile ====
# Verilator build and run for the audio loop-back testbench

VERILATOR ?= verilator
TOP       ?= tb_audio_loop
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run fails unless the pass message appears on a line of its own
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
